// ==== sources.f ====
amber_pkg.sv
amber_fetch.sv
amber_decode.sv
amber_execute.sv
amber_writeback.sv
amber_core.sv
amber_tb.sv

// ==== Bender.yml ====
package:
  name: amber

sources:
  - amber_pkg.sv
  - amber_fetch.sv
  - amber_decode.sv
  - amber_execute.sv
  - amber_writeback.sv
  - amber_core.sv
  - target: simulation
    files:
      - amber_tb.sv

// ==== amber_tb.sv ====
`default_nettype none

module amber_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int PROG_LEN      = 24;
    localparam int NUM_ROWS      = 17;
    localparam int RESET_CYCLES  = 16;
    localparam int RETIRE_WAIT   = 20;
    localparam int QUIET_CYCLES  = 10;
    localparam int FIRST_LATENCY = 3;

    logic               iw_clk;
    logic               iw_rst;
    amber_pkg::word_t   imem_addr;
    amber_pkg::word_t   imem_rdata;
    logic               retire_valid;
    amber_pkg::word_t   retire_pc;
    amber_pkg::gp_idx_t retire_tgt;
    amber_pkg::word_t   retire_data;

    amber_pkg::word_t   prog [PROG_LEN];

    string              exp_name [NUM_ROWS];
    amber_pkg::word_t   exp_pc   [NUM_ROWS];
    amber_pkg::gp_idx_t exp_tgt  [NUM_ROWS];
    amber_pkg::word_t   exp_data [NUM_ROWS];

    amber_core i_amber_core (
        .iw_clk       (iw_clk),
        .iw_rst       (iw_rst),
        .imem_addr    (imem_addr),
        .imem_rdata   (imem_rdata),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_tgt   (retire_tgt),
        .retire_data  (retire_data)
    );

    // Instruction memory answers in the same cycle and reads as NOP beyond the table
    assign imem_rdata = (imem_addr < amber_pkg::word_t'(PROG_LEN)) ? prog[imem_addr]
                                                                   : amber_pkg::NOP_WORD;

    always #4 iw_clk = ~iw_clk;

    function automatic amber_pkg::word_t encode_instr(
        input amber_pkg::opc_t opc,
        input int              tgt,
        input int              src,
        input int              imm
    );
        return {opc, amber_pkg::gp_idx_t'(tgt), amber_pkg::gp_idx_t'(src),
                amber_pkg::imm_t'(imm)};
    endfunction

    task automatic load_program();
        for (int a = 0; a < PROG_LEN; a++) begin
            prog[a] = amber_pkg::NOP_WORD;
        end
        prog[0]  = encode_instr(amber_pkg::OPC_MOVI, 1, 0, 5);
        prog[1]  = encode_instr(amber_pkg::OPC_MOVI, 2, 0, -3);
        prog[2]  = encode_instr(amber_pkg::OPC_ADDI, 1, 0, -7);
        prog[3]  = encode_instr(amber_pkg::OPC_ADD,  1, 2, 0);
        prog[4]  = encode_instr(amber_pkg::OPC_MOVI, 3, 0, 'h0f0);
        prog[5]  = encode_instr(amber_pkg::OPC_SUB,  3, 1, 0);
        prog[6]  = encode_instr(amber_pkg::OPC_AND,  3, 1, 0);
        prog[7]  = encode_instr(amber_pkg::OPC_MOVI, 4, 0, 'h70a);
        prog[8]  = encode_instr(amber_pkg::OPC_OR,   3, 4, 0);
        prog[9]  = encode_instr(amber_pkg::OPC_XOR,  3, 4, 0);
        prog[10] = encode_instr(amber_pkg::OPC_JMP,  0, 0, 3);
        // Jump shadow that must never retire
        prog[11] = encode_instr(amber_pkg::OPC_MOVI, 9, 0, 'h111);
        prog[12] = encode_instr(amber_pkg::OPC_MOVI, 10, 0, 'h222);
        prog[13] = encode_instr(amber_pkg::OPC_SUB,  3, 3, 0);
        prog[14] = encode_instr(amber_pkg::OPC_BEQZ, 3, 0, 3);
        prog[15] = encode_instr(amber_pkg::OPC_MOVI, 11, 0, 1);
        prog[16] = encode_instr(amber_pkg::OPC_MOVI, 12, 0, 1);
        prog[17] = encode_instr(amber_pkg::OPC_BEQZ, 4, 0, 5);
        prog[18] = encode_instr(amber_pkg::OPC_MOVI, 6, 0, 3);
        prog[19] = encode_instr(amber_pkg::OPC_MOVI, 7, 0, 'h7ff);
        // Count r6 down to zero, then leave the loop
        prog[20] = encode_instr(amber_pkg::OPC_ADDI, 6, 0, -1);
        prog[21] = encode_instr(amber_pkg::OPC_BEQZ, 6, 0, 2);
        prog[22] = encode_instr(amber_pkg::OPC_JMP,  0, 0, -2);
        prog[23] = encode_instr(amber_pkg::OPC_MOVI, 8, 0, 'h800);
    endtask

    task automatic put_expected(
        input int    row,
        input string name,
        input int    pc,
        input int    tgt,
        input int    data
    );
        exp_name[row] = name;
        exp_pc[row]   = amber_pkg::word_t'(pc);
        exp_tgt[row]  = amber_pkg::gp_idx_t'(tgt);
        exp_data[row] = amber_pkg::word_t'(data);
    endtask

    task automatic load_expected();
        put_expected(0,  "movi_pos",     0,  1, 'h000005);
        put_expected(1,  "movi_neg",     1,  2, 'hfffffd);
        put_expected(2,  "addi_neg",     2,  1, 'hfffffe);
        put_expected(3,  "add_fwd",      3,  1, 'hfffffb);
        put_expected(4,  "movi_mask",    4,  3, 'h0000f0);
        put_expected(5,  "sub_fwd",      5,  3, 'h0000f5);
        put_expected(6,  "and_fwd",      6,  3, 'h0000f1);
        put_expected(7,  "movi_r4",      7,  4, 'h00070a);
        put_expected(8,  "or_fwd",       8,  3, 'h0007fb);
        put_expected(9,  "xor_through",  9,  3, 'h0000f1);
        put_expected(10, "jmp_target",   13, 3, 'h000000);
        put_expected(11, "beqz_fall_1",  18, 6, 'h000003);
        put_expected(12, "beqz_fall_2",  19, 7, 'h0007ff);
        put_expected(13, "loop_iter_1",  20, 6, 'h000002);
        put_expected(14, "loop_iter_2",  20, 6, 'h000001);
        put_expected(15, "loop_iter_3",  20, 6, 'h000000);
        put_expected(16, "loop_exit",    23, 8, 'hfff800);
    endtask

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_field(
        input string            test,
        input string            field,
        input amber_pkg::word_t expected,
        input amber_pkg::word_t actual
    );
        assert (actual === expected) else begin
            stop_run($sformatf("[FAIL] %s %s expected %h actual %h",
                               test, field, expected, actual));
        end
    endtask

    // Counts falling edges until a retire shows up
    task automatic wait_retire(input string test, output int cycles);
        cycles = 0;
        do begin
            @(negedge iw_clk);
            cycles++;
        end while (!retire_valid && (cycles < RETIRE_WAIT));
        assert (retire_valid === 1'b1) else begin
            stop_run($sformatf("Timeout: %s did not retire within %0d cycles",
                               test, RETIRE_WAIT));
        end
    endtask

    initial begin
        int waited;

        iw_clk = 1'b0;
        iw_rst = 1'b1;
        load_program();
        load_expected();

        repeat (RESET_CYCLES) begin
            @(negedge iw_clk);
            assert (retire_valid === 1'b0) else begin
                stop_run("retire_valid went high while reset was held");
            end
            assert (imem_addr === '0) else begin
                stop_run("imem_addr left address 0 while reset was held");
            end
        end
        iw_rst = 1'b0;

        for (int row = 0; row < NUM_ROWS; row++) begin
            wait_retire(exp_name[row], waited);
            if (row == 0) begin
                assert (waited == FIRST_LATENCY) else begin
                    stop_run($sformatf("[FAIL] %s latency expected %0d actual %0d",
                                       exp_name[row], FIRST_LATENCY, waited));
                end
            end
            check_field(exp_name[row], "retire_pc", exp_pc[row], retire_pc);
            check_field(exp_name[row], "retire_tgt", amber_pkg::word_t'(exp_tgt[row]),
                        amber_pkg::word_t'(retire_tgt));
            check_field(exp_name[row], "retire_data", exp_data[row], retire_data);
        end

        // Past the loop exit only NOPs remain
        repeat (QUIET_CYCLES) begin
            @(negedge iw_clk);
            assert (retire_valid === 1'b0) else begin
                stop_run($sformatf("Unexpected retire at pc %h after the last expected one",
                                   retire_pc));
            end
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== amber_core.sv ====
`default_nettype none

module amber_core (
    input  wire logic              iw_clk,
    input  wire logic              iw_rst,
    output amber_pkg::word_t       imem_addr,
    input  wire amber_pkg::word_t  imem_rdata,
    output logic                   retire_valid,
    output amber_pkg::word_t       retire_pc,
    output amber_pkg::gp_idx_t     retire_tgt,
    output amber_pkg::word_t       retire_data
);

    logic               redirect;
    amber_pkg::word_t   redirect_pc;

    logic               if_valid;
    amber_pkg::word_t   if_pc;
    amber_pkg::word_t   if_instr;

    amber_pkg::gp_idx_t rd_a_idx;
    amber_pkg::gp_idx_t rd_b_idx;
    amber_pkg::word_t   rd_a_val;
    amber_pkg::word_t   rd_b_val;

    logic               ex_valid;
    amber_pkg::word_t   ex_pc;
    amber_pkg::opc_t    ex_opc;
    amber_pkg::gp_idx_t ex_tgt;
    amber_pkg::gp_idx_t ex_src;
    amber_pkg::word_t   ex_imm;
    amber_pkg::word_t   ex_a_val;
    amber_pkg::word_t   ex_b_val;

    logic               wb_valid;
    amber_pkg::word_t   wb_pc;
    amber_pkg::gp_idx_t wb_tgt;
    amber_pkg::word_t   wb_data;

    amber_fetch i_amber_fetch (
        .iw_clk      (iw_clk),
        .iw_rst      (iw_rst),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_rdata  (imem_rdata),
        .imem_addr   (imem_addr),
        .if_valid    (if_valid),
        .if_pc       (if_pc),
        .if_instr    (if_instr)
    );

    amber_decode i_amber_decode (
        .iw_clk   (iw_clk),
        .iw_rst   (iw_rst),
        .if_valid (if_valid),
        .if_pc    (if_pc),
        .if_instr (if_instr),
        .redirect (redirect),
        .rd_a_val (rd_a_val),
        .rd_b_val (rd_b_val),
        .rd_a_idx (rd_a_idx),
        .rd_b_idx (rd_b_idx),
        .ex_valid (ex_valid),
        .ex_pc    (ex_pc),
        .ex_opc   (ex_opc),
        .ex_tgt   (ex_tgt),
        .ex_src   (ex_src),
        .ex_imm   (ex_imm),
        .ex_a_val (ex_a_val),
        .ex_b_val (ex_b_val)
    );

    // Writeback register loops back for forwarding
    amber_execute i_amber_execute (
        .iw_clk      (iw_clk),
        .iw_rst      (iw_rst),
        .ex_valid    (ex_valid),
        .ex_pc       (ex_pc),
        .ex_opc      (ex_opc),
        .ex_tgt      (ex_tgt),
        .ex_src      (ex_src),
        .ex_imm      (ex_imm),
        .ex_a_val    (ex_a_val),
        .ex_b_val    (ex_b_val),
        .fwd_valid   (wb_valid),
        .fwd_tgt     (wb_tgt),
        .fwd_data    (wb_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .wb_valid    (wb_valid),
        .wb_pc       (wb_pc),
        .wb_tgt      (wb_tgt),
        .wb_data     (wb_data)
    );

    amber_writeback i_amber_writeback (
        .iw_clk       (iw_clk),
        .iw_rst       (iw_rst),
        .wb_valid     (wb_valid),
        .wb_pc        (wb_pc),
        .wb_tgt       (wb_tgt),
        .wb_data      (wb_data),
        .rd_a_idx     (rd_a_idx),
        .rd_b_idx     (rd_b_idx),
        .rd_a_val     (rd_a_val),
        .rd_b_val     (rd_b_val),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_tgt   (retire_tgt),
        .retire_data  (retire_data)
    );

endmodule

`default_nettype wire

// ==== amber_writeback.sv ====
`default_nettype none

module amber_writeback (
    input  wire logic                iw_clk,
    input  wire logic                iw_rst,
    input  wire logic                wb_valid,
    input  wire amber_pkg::word_t    wb_pc,
    input  wire amber_pkg::gp_idx_t  wb_tgt,
    input  wire amber_pkg::word_t    wb_data,
    input  wire amber_pkg::gp_idx_t  rd_a_idx,
    input  wire amber_pkg::gp_idx_t  rd_b_idx,
    output amber_pkg::word_t         rd_a_val,
    output amber_pkg::word_t         rd_b_val,
    output logic                     retire_valid,
    output amber_pkg::word_t         retire_pc,
    output amber_pkg::gp_idx_t       retire_tgt,
    output amber_pkg::word_t         retire_data
);

    amber_pkg::word_t gp_regs [amber_pkg::GP_COUNT];

    // A write landing this cycle wins over the stored value
    function automatic amber_pkg::word_t read_port(
        input amber_pkg::gp_idx_t idx,
        input amber_pkg::word_t   stored
    );
        if (wb_valid && (wb_tgt == idx)) begin
            return wb_data;
        end
        return stored;
    endfunction

    always_comb begin
        rd_a_val = read_port(rd_a_idx, gp_regs[rd_a_idx]);
        rd_b_val = read_port(rd_b_idx, gp_regs[rd_b_idx]);
    end

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            for (int i = 0; i < amber_pkg::GP_COUNT; i++) begin
                gp_regs[i] <= '0;
            end
        end else if (wb_valid) begin
            gp_regs[wb_tgt] <= wb_data;
        end
    end

    // Retire reports the write that commits at the next edge
    assign retire_valid = wb_valid;
    assign retire_pc    = wb_pc;
    assign retire_tgt   = wb_tgt;
    assign retire_data  = wb_data;

endmodule

`default_nettype wire

// ==== amber_execute.sv ====
`default_nettype none

module amber_execute (
    input  wire logic                iw_clk,
    input  wire logic                iw_rst,
    input  wire logic                ex_valid,
    input  wire amber_pkg::word_t    ex_pc,
    input  wire amber_pkg::opc_t     ex_opc,
    input  wire amber_pkg::gp_idx_t  ex_tgt,
    input  wire amber_pkg::gp_idx_t  ex_src,
    input  wire amber_pkg::word_t    ex_imm,
    input  wire amber_pkg::word_t    ex_a_val,
    input  wire amber_pkg::word_t    ex_b_val,
    input  wire logic                fwd_valid,
    input  wire amber_pkg::gp_idx_t  fwd_tgt,
    input  wire amber_pkg::word_t    fwd_data,
    output logic                     redirect,
    output amber_pkg::word_t         redirect_pc,
    output logic                     wb_valid,
    output amber_pkg::word_t         wb_pc,
    output amber_pkg::gp_idx_t       wb_tgt,
    output amber_pkg::word_t         wb_data
);

    amber_pkg::word_t src_op;
    amber_pkg::word_t tgt_op;
    amber_pkg::word_t alu_result;
    logic             writes_reg;
    logic             tgt_is_zero;

    // The instruction one ahead is sitting in the writeback register
    assign src_op = (fwd_valid && (fwd_tgt == ex_src)) ? fwd_data : ex_a_val;
    assign tgt_op = (fwd_valid && (fwd_tgt == ex_tgt)) ? fwd_data : ex_b_val;

    assign tgt_is_zero = (tgt_op == '0);

    always_comb begin
        alu_result = '0;
        writes_reg = 1'b0;
        case (ex_opc)
            amber_pkg::OPC_ADD: begin
                alu_result = tgt_op + src_op;
                writes_reg = 1'b1;
            end
            amber_pkg::OPC_SUB: begin
                alu_result = tgt_op - src_op;
                writes_reg = 1'b1;
            end
            amber_pkg::OPC_AND: begin
                alu_result = tgt_op & src_op;
                writes_reg = 1'b1;
            end
            amber_pkg::OPC_OR: begin
                alu_result = tgt_op | src_op;
                writes_reg = 1'b1;
            end
            amber_pkg::OPC_XOR: begin
                alu_result = tgt_op ^ src_op;
                writes_reg = 1'b1;
            end
            amber_pkg::OPC_MOVI: begin
                alu_result = ex_imm;
                writes_reg = 1'b1;
            end
            amber_pkg::OPC_ADDI: begin
                alu_result = tgt_op + ex_imm;
                writes_reg = 1'b1;
            end
            default: begin
                alu_result = '0;
                writes_reg = 1'b0;
            end
        endcase
    end

    // Both branch kinds are PC relative
    assign redirect_pc = ex_pc + ex_imm;

    always_comb begin
        redirect = 1'b0;
        if (ex_valid) begin
            if (ex_opc == amber_pkg::OPC_JMP) begin
                redirect = 1'b1;
            end else if (ex_opc == amber_pkg::OPC_BEQZ) begin
                redirect = tgt_is_zero;
            end
        end
    end

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            wb_valid <= 1'b0;
            wb_pc    <= '0;
            wb_tgt   <= '0;
            wb_data  <= '0;
        end else begin
            wb_valid <= ex_valid && writes_reg;
            wb_pc    <= ex_pc;
            wb_tgt   <= ex_tgt;
            wb_data  <= alu_result;
        end
    end

endmodule

`default_nettype wire

// ==== amber_decode.sv ====
`default_nettype none

module amber_decode (
    input  wire logic                iw_clk,
    input  wire logic                iw_rst,
    input  wire logic                if_valid,
    input  wire amber_pkg::word_t    if_pc,
    input  wire amber_pkg::word_t    if_instr,
    input  wire logic                redirect,
    input  wire amber_pkg::word_t    rd_a_val,
    input  wire amber_pkg::word_t    rd_b_val,
    output amber_pkg::gp_idx_t       rd_a_idx,
    output amber_pkg::gp_idx_t       rd_b_idx,
    output logic                     ex_valid,
    output amber_pkg::word_t         ex_pc,
    output amber_pkg::opc_t          ex_opc,
    output amber_pkg::gp_idx_t       ex_tgt,
    output amber_pkg::gp_idx_t       ex_src,
    output amber_pkg::word_t         ex_imm,
    output amber_pkg::word_t         ex_a_val,
    output amber_pkg::word_t         ex_b_val
);

    amber_pkg::opc_t    if_opc;
    amber_pkg::gp_idx_t if_tgt;
    amber_pkg::gp_idx_t if_src;
    amber_pkg::imm_t    if_imm;
    amber_pkg::opc_t    opc_legal;
    amber_pkg::word_t   imm_sext;

    assign if_opc = if_instr[amber_pkg::OPC_HI:amber_pkg::OPC_LO];
    assign if_tgt = if_instr[amber_pkg::TGT_HI:amber_pkg::TGT_LO];
    assign if_src = if_instr[amber_pkg::SRC_HI:amber_pkg::SRC_LO];
    assign if_imm = if_instr[amber_pkg::IMM_HI:amber_pkg::IMM_LO];

    // Port a reads the source, port b the target
    assign rd_a_idx = if_src;
    assign rd_b_idx = if_tgt;

    assign opc_legal = (if_opc > amber_pkg::OPC_BEQZ) ? amber_pkg::OPC_NOP : if_opc;
    assign imm_sext  = {{(amber_pkg::WORD_W - amber_pkg::IMM_W){if_imm[amber_pkg::IMM_W-1]}},
                        if_imm};

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            ex_valid <= 1'b0;
            ex_pc    <= '0;
            ex_opc   <= amber_pkg::OPC_NOP;
            ex_tgt   <= '0;
            ex_src   <= '0;
            ex_imm   <= '0;
            ex_a_val <= '0;
            ex_b_val <= '0;
        end else begin
            // Branch in execute squashes the instruction being decoded
            ex_valid <= if_valid && !redirect;
            ex_pc    <= if_pc;
            ex_opc   <= opc_legal;
            ex_tgt   <= if_tgt;
            ex_src   <= if_src;
            ex_imm   <= imm_sext;
            ex_a_val <= rd_a_val;
            ex_b_val <= rd_b_val;
        end
    end

endmodule

`default_nettype wire

// ==== amber_fetch.sv ====
`default_nettype none

module amber_fetch (
    input  wire logic              iw_clk,
    input  wire logic              iw_rst,
    input  wire logic              redirect,
    input  wire amber_pkg::word_t  redirect_pc,
    input  wire amber_pkg::word_t  imem_rdata,
    output amber_pkg::word_t       imem_addr,
    output logic                   if_valid,
    output amber_pkg::word_t       if_pc,
    output amber_pkg::word_t       if_instr
);

    amber_pkg::word_t pc;

    // Memory answers in the same cycle, so the PC goes straight out
    assign imem_addr = pc;

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            pc       <= '0;
            if_valid <= 1'b0;
            if_pc    <= '0;
            if_instr <= amber_pkg::NOP_WORD;
        end else if (redirect) begin
            // Word fetched this cycle is on the wrong path
            pc       <= redirect_pc;
            if_valid <= 1'b0;
            if_pc    <= pc;
            if_instr <= amber_pkg::NOP_WORD;
        end else begin
            pc       <= pc + amber_pkg::word_t'(1);
            if_valid <= 1'b1;
            if_pc    <= pc;
            if_instr <= imem_rdata;
        end
    end

endmodule

`default_nettype wire

// ==== amber_pkg.sv ====
`default_nettype none

package amber_pkg;

    localparam int WORD_W   = 24;
    localparam int GP_IDX_W = 4;
    localparam int OPC_W    = 4;
    localparam int IMM_W    = 12;
    localparam int GP_COUNT = 16;

    // Data, address and instruction share one width
    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [GP_IDX_W-1:0] gp_idx_t;
    typedef logic [OPC_W-1:0]    opc_t;
    typedef logic [IMM_W-1:0]    imm_t;

    // Instruction field positions
    localparam int OPC_HI = 23;
    localparam int OPC_LO = 20;
    localparam int TGT_HI = 19;
    localparam int TGT_LO = 16;
    localparam int SRC_HI = 15;
    localparam int SRC_LO = 12;
    localparam int IMM_HI = 11;
    localparam int IMM_LO = 0;

    // Anything above OPC_BEQZ decodes as a NOP
    localparam opc_t OPC_NOP  = 4'd0;
    localparam opc_t OPC_ADD  = 4'd1;
    localparam opc_t OPC_SUB  = 4'd2;
    localparam opc_t OPC_AND  = 4'd3;
    localparam opc_t OPC_OR   = 4'd4;
    localparam opc_t OPC_XOR  = 4'd5;
    localparam opc_t OPC_MOVI = 4'd6;
    localparam opc_t OPC_ADDI = 4'd7;
    localparam opc_t OPC_JMP  = 4'd8;
    localparam opc_t OPC_BEQZ = 4'd9;

    // Bubble inserted by fetch on a redirect
    localparam word_t NOP_WORD = '0;

endpackage

`default_nettype wire
